// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = uart_alu_tb
FILELIST  = uart_alu_top.f
BUILD_DIR = obj_dir
PASS_TEXT = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/alu_pkg.sv ====
package alu_pkg;

    // Operand and result width
    localparam int ALU_WIDTH = 8;

    // Opcode field width, low bits of the first command byte
    localparam int OPCODE_BITS = 6;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    localparam logic [OPCODE_BITS-1:0] OP_ADD = 6'b100000;
    localparam logic [OPCODE_BITS-1:0] OP_SUB = 6'b100010;
    localparam logic [OPCODE_BITS-1:0] OP_AND = 6'b100100;
    localparam logic [OPCODE_BITS-1:0] OP_OR  = 6'b100101;
    localparam logic [OPCODE_BITS-1:0] OP_XOR = 6'b100110;
    localparam logic [OPCODE_BITS-1:0] OP_NOR = 6'b100111;
    localparam logic [OPCODE_BITS-1:0] OP_SRL = 6'b000010;
    localparam logic [OPCODE_BITS-1:0] OP_SRA = 6'b000011;

    // One assembled command, opcode first on the wire
    typedef struct packed {
        logic [OPCODE_BITS-1:0] opcode;
        logic [ALU_WIDTH-1:0]   operand_a;
        logic [ALU_WIDTH-1:0]   operand_b;
    } alu_command_t;

endpackage

// ==== common/uart_pkg.sv ====
package uart_pkg;

    ////////////////////////////////////////
    // Serial framing
    ////////////////////////////////////////

    // Bits per serial word, 8N1 framing
    localparam int DATA_BITS = 8;

    // Receiver samples per bit period
    localparam int OVERSAMPLE = 16;

    // Clocks per oversampling tick, kept small for fast simulation
    localparam int BAUD_DIVISOR = 4;

    ////////////////////////////////////////
    // Buffering
    ////////////////////////////////////////

    localparam int RX_FIFO_DEPTH = 8;
    localparam int TX_FIFO_DEPTH = 4;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  alu_pkg::alu_command_t         i_command,
    output logic [alu_pkg::ALU_WIDTH-1:0] o_result
);

    logic [alu_pkg::ALU_WIDTH-1:0] a;
    logic [alu_pkg::ALU_WIDTH-1:0] b;
    logic [2:0]                    shift_amount;

    assign a            = i_command.operand_a;
    assign b            = i_command.operand_b;
    assign shift_amount = b[2:0];

    // Add and subtract wrap, no carry out
    always_comb begin
        case (i_command.opcode)
            alu_pkg::OP_ADD: o_result = a + b;
            alu_pkg::OP_SUB: o_result = a - b;
            alu_pkg::OP_AND: o_result = a & b;
            alu_pkg::OP_OR:  o_result = a | b;
            alu_pkg::OP_XOR: o_result = a ^ b;
            alu_pkg::OP_NOR: o_result = ~(a | b);
            alu_pkg::OP_SRL: o_result = a >> shift_amount;
            // Sign bit of A fills from the top
            alu_pkg::OP_SRA: o_result = $signed(a) >>> shift_amount;
            default:         o_result = '0;
        endcase
    end

endmodule

// ==== rtl/alu_command_unit.sv ====
`timescale 1ns/1ps

module alu_command_unit (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic [alu_pkg::ALU_WIDTH-1:0] i_rx_data,
    input  logic                          i_rx_empty,
    output logic                          o_rx_pop,
    output alu_pkg::alu_command_t         o_command,
    input  logic [alu_pkg::ALU_WIDTH-1:0] i_result,
    output logic [alu_pkg::ALU_WIDTH-1:0] o_tx_data,
    output logic                          o_tx_push,
    input  logic                          i_tx_full
);

    // Which byte comes next, or waiting to queue the result
    typedef enum logic [1:0] {ST_OPCODE, ST_OPERAND_A, ST_OPERAND_B, ST_ISSUE} cmd_state_t;

    cmd_state_t            state;
    alu_pkg::alu_command_t command;

    ////////////////////////////////////////
    // Byte collection
    ////////////////////////////////////////

    // One byte per cycle while the receive FIFO has data
    assign o_rx_pop = (state != ST_ISSUE) && !i_rx_empty;

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state <= ST_OPCODE;
        end else begin
            case (state)
                ST_OPCODE:    if (o_rx_pop) state <= ST_OPERAND_A;
                ST_OPERAND_A: if (o_rx_pop) state <= ST_OPERAND_B;
                ST_OPERAND_B: if (o_rx_pop) state <= ST_ISSUE;
                default:      if (o_tx_push) state <= ST_OPCODE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_rx_pop) begin
            case (state)
                ST_OPCODE:    command.opcode    <= i_rx_data[alu_pkg::OPCODE_BITS-1:0];
                ST_OPERAND_A: command.operand_a <= i_rx_data;
                default:      command.operand_b <= i_rx_data;
            endcase
        end
    end

    assign o_command = command;

    ////////////////////////////////////////
    // Result queueing
    ////////////////////////////////////////

    // Command held steady, so the ALU output is taken as is
    assign o_tx_data = i_result;
    assign o_tx_push = (state == ST_ISSUE) && !i_tx_full;

endmodule

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_push,
    input  logic                           i_pop,
    input  logic [uart_pkg::DATA_BITS-1:0] i_data,
    output logic [uart_pkg::DATA_BITS-1:0] o_data,
    output logic                           o_empty,
    output logic                           o_full
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    logic [uart_pkg::DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0]            wr_ptr;
    logic [PTR_BITS-1:0]            rd_ptr;
    logic [COUNT_BITS-1:0]          count;
    logic                           do_push;
    logic                           do_pop;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] advance(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == COUNT_BITS'(DEPTH));
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // Head is visible without a read request
    assign o_data = mem[rd_ptr];

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

// ==== rtl/uart_alu_top.sv ====
`timescale 1ns/1ps

module uart_alu_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx_serial,
    output logic o_tx_serial
);

    logic                           tick;
    logic [uart_pkg::DATA_BITS-1:0] rx_byte;
    logic                           rx_valid;
    logic [uart_pkg::DATA_BITS-1:0] rx_head;
    logic                           rx_empty;
    logic                           rx_pop;
    alu_pkg::alu_command_t          command;
    logic [alu_pkg::ALU_WIDTH-1:0]  result;
    logic [uart_pkg::DATA_BITS-1:0] tx_byte;
    logic                           tx_push;
    logic                           tx_full;
    logic [uart_pkg::DATA_BITS-1:0] tx_head;
    logic                           tx_empty;
    logic                           tx_pop;

    uart_baud_gen baud_gen (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    ////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////

    uart_rx receiver (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_tick   (tick),
        .i_serial (i_rx_serial),
        .o_data   (rx_byte),
        .o_valid  (rx_valid)
    );

    // Overflow bytes are dropped inside the FIFO
    byte_fifo #(.DEPTH(uart_pkg::RX_FIFO_DEPTH)) rx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_push  (rx_valid),
        .i_pop   (rx_pop),
        .i_data  (rx_byte),
        .o_data  (rx_head),
        .o_empty (rx_empty),
        .o_full  ()
    );

    ////////////////////////////////////////
    // Command handling
    ////////////////////////////////////////

    alu_command_unit command_unit (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_data  (rx_head),
        .i_rx_empty (rx_empty),
        .o_rx_pop   (rx_pop),
        .o_command  (command),
        .i_result   (result),
        .o_tx_data  (tx_byte),
        .o_tx_push  (tx_push),
        .i_tx_full  (tx_full)
    );

    alu alu_core (
        .i_command (command),
        .o_result  (result)
    );

    ////////////////////////////////////////
    // Transmit side
    ////////////////////////////////////////

    byte_fifo #(.DEPTH(uart_pkg::TX_FIFO_DEPTH)) tx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_push  (tx_push),
        .i_pop   (tx_pop),
        .i_data  (tx_byte),
        .o_data  (tx_head),
        .o_empty (tx_empty),
        .o_full  (tx_full)
    );

    uart_tx transmitter (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_tick       (tick),
        .i_fifo_empty (tx_empty),
        .i_data       (tx_head),
        .o_fifo_rd    (tx_pop),
        .o_serial     (o_tx_serial)
    );

endmodule

// ==== uart/uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    localparam int COUNT_BITS = (uart_pkg::BAUD_DIVISOR > 1) ?
        $clog2(uart_pkg::BAUD_DIVISOR) : 1;
    localparam logic [COUNT_BITS-1:0] LAST_COUNT = COUNT_BITS'(uart_pkg::BAUD_DIVISOR - 1);

    logic [COUNT_BITS-1:0] count;

    // Free-running divider, wraps after the last count
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            count <= '0;
        end else if (count == LAST_COUNT) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign o_tick = (count == LAST_COUNT);

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_tick,
    input  logic                           i_serial,
    output logic [uart_pkg::DATA_BITS-1:0] o_data,
    output logic                           o_valid
);

    localparam int TICK_BITS = $clog2(uart_pkg::OVERSAMPLE);
    localparam int BIT_BITS  = $clog2(uart_pkg::DATA_BITS);
    localparam logic [TICK_BITS-1:0] HALF_TICK = TICK_BITS'(uart_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TICK_BITS-1:0] LAST_TICK = TICK_BITS'(uart_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_BITS-1:0]  LAST_BIT  = BIT_BITS'(uart_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

    rx_state_t                    state;
    logic [1:0]                   sync;
    logic                         serial_s;
    logic [TICK_BITS-1:0]         tick_count;
    logic [BIT_BITS-1:0]          bit_count;
    logic [uart_pkg::DATA_BITS-1:0] shift_reg;
    logic                         bit_end;

    assign serial_s = sync[1];
    assign bit_end  = i_tick && (tick_count == LAST_TICK);

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state      <= ST_IDLE;
            sync       <= 2'b11;
            tick_count <= '0;
            bit_count  <= '0;
            o_valid    <= 1'b0;
        end else begin
            sync    <= {sync[0], i_serial};
            o_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!serial_s) begin
                        state      <= ST_START;
                        tick_count <= '0;
                    end
                end
                ST_START: begin
                    if (i_tick) begin
                        // Mid start bit, a glitch has gone high again
                        if (tick_count == HALF_TICK) begin
                            tick_count <= '0;
                            bit_count  <= '0;
                            state      <= serial_s ? ST_IDLE : ST_DATA;
                        end else begin
                            tick_count <= tick_count + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        tick_count <= '0;
                        if (bit_count == LAST_BIT) begin
                            state <= ST_STOP;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end else if (i_tick) begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        o_valid <= serial_s;
                        state   <= ST_IDLE;
                    end else if (i_tick) begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clock) begin
        if (state == ST_DATA && bit_end) begin
            shift_reg <= {serial_s, shift_reg[uart_pkg::DATA_BITS-1:1]};
        end
    end

    assign o_data = shift_reg;

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_tick,
    input  logic                           i_fifo_empty,
    input  logic [uart_pkg::DATA_BITS-1:0] i_data,
    output logic                           o_fifo_rd,
    output logic                           o_serial
);

    // Idle bit, start bit, data, stop bit
    localparam int FRAME_BITS = uart_pkg::DATA_BITS + 3;
    localparam int TICK_BITS  = $clog2(uart_pkg::OVERSAMPLE);
    localparam int SHIFT_BITS = $clog2(FRAME_BITS);
    localparam logic [TICK_BITS-1:0]  LAST_TICK  = TICK_BITS'(uart_pkg::OVERSAMPLE - 1);
    localparam logic [SHIFT_BITS-1:0] LAST_SHIFT = SHIFT_BITS'(FRAME_BITS - 1);

    logic                   busy;
    logic [FRAME_BITS-1:0]  frame;
    logic [TICK_BITS-1:0]   tick_count;
    logic [SHIFT_BITS-1:0]  shift_count;

    assign o_fifo_rd = !busy && !i_fifo_empty;

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            busy        <= 1'b0;
            frame       <= '1;
            tick_count  <= '0;
            shift_count <= '0;
        end else if (o_fifo_rd) begin
            // Low bit stays high so the start bit lines up with the next tick
            busy        <= 1'b1;
            frame       <= {1'b1, i_data, 1'b0, 1'b1};
            tick_count  <= LAST_TICK;
            shift_count <= '0;
        end else if (busy && i_tick) begin
            if (tick_count == LAST_TICK) begin
                tick_count  <= '0;
                frame       <= {1'b1, frame[FRAME_BITS-1:1]};
                shift_count <= shift_count + 1'b1;
                // Full stop bit sent
                if (shift_count == LAST_SHIFT) begin
                    busy <= 1'b0;
                end
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

    assign o_serial = frame[0];

endmodule

// ==== uart_alu_top.f ====
common/uart_pkg.sv
common/alu_pkg.sv
uart/uart_baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/byte_fifo.sv
rtl/alu.sv
rtl/alu_command_unit.sv
rtl/uart_alu_top.sv
verification/uart_alu_tb.sv

// ==== verification/uart_alu_tb.sv ====
`timescale 1ns/1ps

module uart_alu_tb;

    localparam int BIT_CLOCKS   = uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIVISOR;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 1000;
    localparam int BYTE_GAP     = 1500;
    // Roughly 73000 cycles of traffic over all five tests with margin on top
    localparam int TIMEOUT_CYCLES = 100000;

    logic        i_clock;
    logic        i_reset;
    logic        i_rx_serial;
    logic        o_tx_serial;
    logic [7:0]  expected[$];
    logic [7:0]  received[$];
    logic [31:0] seed;
    int          error_count = 0;
    int          frames_started = 0;
    int          cycles = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    uart_alu_top dut (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx_serial (i_rx_serial),
        .o_tx_serial (o_tx_serial)
    );

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    ////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////

    function automatic logic [7:0] expected_result(input logic [7:0] op_byte,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
        logic [2:0] shift;
        logic [7:0] fill;
        shift = b[2:0];
        fill  = ~(8'hFF >> shift);
        // Only the low six bits of the first byte select the operation
        case (op_byte[5:0])
            alu_pkg::OP_ADD: return a + b;
            alu_pkg::OP_SUB: return a - b;
            alu_pkg::OP_AND: return a & b;
            alu_pkg::OP_OR:  return a | b;
            alu_pkg::OP_XOR: return a ^ b;
            alu_pkg::OP_NOR: return ~(a | b);
            alu_pkg::OP_SRL: return a >> shift;
            alu_pkg::OP_SRA: return (a >> shift) | (a[7] ? fill : 8'h00);
            default:         return 8'h00;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [5:0] opcode_from_index(input logic [2:0] index);
        case (index)
            3'd0:    return alu_pkg::OP_ADD;
            3'd1:    return alu_pkg::OP_SUB;
            3'd2:    return alu_pkg::OP_AND;
            3'd3:    return alu_pkg::OP_OR;
            3'd4:    return alu_pkg::OP_XOR;
            3'd5:    return alu_pkg::OP_NOR;
            3'd6:    return alu_pkg::OP_SRL;
            default: return alu_pkg::OP_SRA;
        endcase
    endfunction

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_rx_serial <= frame[i];
            repeat (BIT_CLOCKS - 1) @(posedge i_clock);
        end
    endtask

    task automatic send_command(input logic [7:0] op_byte, input logic [7:0] a,
                                input logic [7:0] b);
        expected.push_back(expected_result(op_byte, a, b));
        send_byte(op_byte);
        send_byte(a);
        send_byte(b);
    endtask

    task automatic wait_for_results();
        while (expected.size() != 0) begin
            @(posedge i_clock);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////
    // Serial monitor and compare
    ////////////////////////////////////////

    // Samples each bit at its middle on the falling clock
    initial begin : monitor
        logic [7:0] data;
        forever begin
            @(negedge o_tx_serial);
            frames_started++;
            repeat (BIT_CLOCKS / 2) @(negedge i_clock);
            if (o_tx_serial !== 1'b0) begin
                $display("Start bit on o_tx_serial was not low at its middle, time %0t", $time);
                error_count++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLOCKS) @(negedge i_clock);
                data[i] = o_tx_serial;
            end
            repeat (BIT_CLOCKS) @(negedge i_clock);
            if (o_tx_serial !== 1'b1) begin
                $display("Stop bit on o_tx_serial was low at time %0t", $time);
                error_count++;
            end
            received.push_back(data);
        end
    end

    initial begin : compare
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge i_clock);
            if (received.size() != 0) begin
                got = received.pop_front();
                if (expected.size() == 0) begin
                    $display("Byte %02h arrived on o_tx_serial with no result pending", got);
                    error_count++;
                end else begin
                    want = expected.pop_front();
                    if (got !== want) begin
                        $display("Fail at %0t: o_tx_serial = %02h, expected %02h",
                                 $time, got, want);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    initial begin : stimulus
        int         errors_at_start;
        int         frames_before;
        logic [7:0] op_byte;
        logic [7:0] a;
        logic [7:0] b;
        i_reset     <= 1'b1;
        i_rx_serial <= 1'b1;
        seed        = 32'h6cff_5ffb;

        errors_at_start = error_count;
        repeat (RESET_CYCLES) begin
            @(posedge i_clock);
            if (o_tx_serial !== 1'b1) begin
                $display("Fail at %0t: o_tx_serial = %b, expected 1", $time, o_tx_serial);
                error_count++;
            end
        end
        i_reset <= 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge i_clock);
            if (o_tx_serial !== 1'b1) begin
                $display("Fail at %0t: o_tx_serial = %b, expected 1", $time, o_tx_serial);
                error_count++;
            end
        end
        if (frames_started != 0) begin
            $display("A start bit appeared on o_tx_serial while the device was idle");
            error_count++;
        end
        finish_test("idle after reset", errors_at_start);

        // Carry, borrow and sign fill cases
        errors_at_start = error_count;
        send_command({2'b00, alu_pkg::OP_ADD}, 8'hF0, 8'h25);
        send_command({2'b00, alu_pkg::OP_SUB}, 8'h10, 8'h20);
        send_command({2'b00, alu_pkg::OP_AND}, 8'hCA, 8'h5F);
        send_command({2'b00, alu_pkg::OP_OR}, 8'h81, 8'h14);
        send_command({2'b00, alu_pkg::OP_XOR}, 8'hAA, 8'h0F);
        send_command({2'b00, alu_pkg::OP_NOR}, 8'h12, 8'h40);
        send_command({2'b00, alu_pkg::OP_SRL}, 8'hB4, 8'h03);
        send_command({2'b00, alu_pkg::OP_SRA}, 8'h96, 8'h02);
        send_command({2'b00, alu_pkg::OP_SRA}, 8'h6C, 8'hFD);
        wait_for_results();
        finish_test("each opcode once", errors_at_start);

        errors_at_start = error_count;
        send_command(8'h00, 8'h5A, 8'h33);
        send_command(8'h3F, 8'hFF, 8'h01);
        send_command({2'b11, alu_pkg::OP_ADD}, 8'h7F, 8'h01);
        wait_for_results();
        finish_test("unknown opcodes", errors_at_start);

        errors_at_start = error_count;
        for (int n = 0; n < 16; n++) begin
            seed    = lcg_next(seed);
            op_byte = {2'b00, opcode_from_index(seed[30:28])};
            seed    = lcg_next(seed);
            a       = seed[23:16];
            seed    = lcg_next(seed);
            b       = seed[23:16];
            send_command(op_byte, a, b);
        end
        wait_for_results();
        finish_test("back-to-back commands", errors_at_start);

        // Nothing may leave before the third byte is in
        errors_at_start = error_count;
        for (int n = 0; n < 3; n++) begin
            seed    = lcg_next(seed);
            op_byte = {2'b00, opcode_from_index(seed[30:28])};
            seed    = lcg_next(seed);
            a       = seed[23:16];
            seed    = lcg_next(seed);
            b       = seed[23:16];
            frames_before = frames_started;
            expected.push_back(expected_result(op_byte, a, b));
            send_byte(op_byte);
            repeat (BYTE_GAP) @(posedge i_clock);
            send_byte(a);
            repeat (BYTE_GAP) @(posedge i_clock);
            if (frames_started != frames_before) begin
                $display("A result started on o_tx_serial before the third byte was sent");
                error_count++;
            end
            send_byte(b);
            wait_for_results();
        end
        finish_test("spacing between bytes", errors_at_start);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
